// File: src/fetch_pkg.sv
// shared definitions for the instruction fetch subsystem
// widths, opcodes, reset vector and the bus and predecode structs
// every file refers to these by scoped name
package fetch_pkg;

   // pc and bus address width
   localparam int ADDR_W = 32;
   // instruction word width
   localparam int INSN_W = 32;
   // rom index width, 64 words
   localparam int ROM_AW = 6;

   // first fetch address after reset, also the rom base
   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

   // major opcodes, instruction bits 31:26
   localparam logic [5:0] OPC_J    = 6'h00;
   localparam logic [5:0] OPC_JAL  = 6'h01;
   localparam logic [5:0] OPC_BNF  = 6'h03;
   localparam logic [5:0] OPC_BF   = 6'h04;
   localparam logic [5:0] OPC_NOP  = 6'h05;
   localparam logic [5:0] OPC_SYS  = 6'h08;
   localparam logic [5:0] OPC_JR   = 6'h11;
   localparam logic [5:0] OPC_JALR = 6'h12;

   // bubble placed on decode when a slot is killed
   localparam logic [INSN_W-1:0] NOP_INSN = {OPC_NOP, 26'd0};

   // request side of the instruction bus, driven by fetch
   typedef struct packed {
      logic              req;
      logic [ADDR_W-1:0] adr;
   } ibus_req_t;

   // response side of the instruction bus, driven by the rom
   // ack and err are single cycle and never high together
   typedef struct packed {
      logic              ack;
      logic              err;
      logic [INSN_W-1:0] dat;
   } ibus_rsp_t;

   // early classification of a returned word
   typedef struct packed {
      // word redirects flow
      logic              will_branch;
      // target is known from the word itself
      logic              has_target;
      logic [ADDR_W-1:0] target;
      // jump to self, used as sleep
      logic              self_loop;
   } predecode_t;

endpackage

// File: src/fetch_predecode.sv
// combinational predecoder for the word returned on the instruction bus
// classifies the opcode and computes the pc-relative branch target
// so fetch can redirect before the word reaches decode
module fetch_predecode
(
   input  logic [fetch_pkg::INSN_W-1:0] insn_i,
   input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
   input  logic                         flag_i,
   input  logic                         flag_set_i,
   input  logic                         flag_clear_i,
   output fetch_pkg::predecode_t        pre_o
);

   logic [5:0]                   opc;
   logic                         bf_taken;
   logic                         bnf_taken;
   logic                         branch;
   logic                         known;
   logic [fetch_pkg::ADDR_W-1:0] offset;
   logic [fetch_pkg::ADDR_W-1:0] target;

   assign opc = insn_i[31:26];

   // flag as execute will see it, set/clear in flight win over the register
   assign bf_taken  = (flag_i & !flag_clear_i) | flag_set_i;
   assign bnf_taken = !(flag_i | flag_set_i) | flag_clear_i;

   // 26-bit word offset, sign extended and scaled to bytes
   assign offset = {{4{insn_i[25]}}, insn_i[25:0], 2'b00};
   assign target = pc_i + offset;

   always_comb
   begin
      branch = 1'b0;
      known  = 1'b0;
      case (opc)
         fetch_pkg::OPC_J,
         fetch_pkg::OPC_JAL:
         begin
            branch = 1'b1;
            known  = 1'b1;
         end
         // not-taken conditional just falls through
         fetch_pkg::OPC_BF:
         begin
            branch = bf_taken;
            known  = bf_taken;
         end
         fetch_pkg::OPC_BNF:
         begin
            branch = bnf_taken;
            known  = bnf_taken;
         end
         // register or trap targets come from execute
         fetch_pkg::OPC_JR,
         fetch_pkg::OPC_JALR,
         fetch_pkg::OPC_SYS:
         begin
            branch = 1'b1;
         end
         default:
         begin
            branch = 1'b0;
         end
      endcase
   end

   assign pre_o.will_branch = branch;
   assign pre_o.has_target  = known;
   assign pre_o.target      = target;
   // target equal to own pc means the core sleeps here
   assign pre_o.self_loop   = known & (target == pc_i);

endmodule

// File: src/fetch_bus_ctrl.sv
// request control for the fetch side of the instruction bus
// holds the request flop and the sleep, error and branch-wait state
// req_o is the gated request handed to the bus
module fetch_bus_ctrl
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  ack_i,
   input  logic                  err_i,
   input  logic                  padv_i,
   input  logic                  except_branch_i,
   input  logic                  branch_occur_i,
   input  fetch_pkg::predecode_t pre_i,
   output logic                  req_o,
   output logic                  sleep_o,
   output logic                  jump_in_decode_o
);

   logic fetch_req;
   logic sleep_q;
   logic err_hold;
   logic wait_branch;
   logic jump_q;
   logic padv_r;
   logic took_branch;
   logic taken;
   logic go_sleep;
   logic start_wait;
   logic padv_deasserted;

   // word is accepted by decode this cycle
   assign taken      = ack_i & padv_i;
   assign go_sleep   = taken & pre_i.self_loop;
   // register-indirect flow, target only known once execute resolves it
   assign start_wait = taken & pre_i.will_branch & !pre_i.has_target;

   // pipeline stalled for its own reasons, not because of a branch
   assign padv_deasserted = padv_r & !padv_i & fetch_req & !took_branch;

   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_req <= 1'b1;
      else if (except_branch_i)
         fetch_req <= 1'b1;
      else if (err_i | err_hold)
         fetch_req <= 1'b0;
      else if (sleep_q | go_sleep)
         fetch_req <= 1'b0;
      else if (start_wait | (wait_branch & !branch_occur_i))
         fetch_req <= 1'b0;
      else if (padv_deasserted)
         fetch_req <= 1'b0;
      else
         fetch_req <= 1'b1;
   end

   // sticky state, only an exception branch leaves it
   always_ff @(posedge clk)
   begin
      if (rst | except_branch_i)
      begin
         sleep_q     <= 1'b0;
         err_hold    <= 1'b0;
         wait_branch <= 1'b0;
      end
      else
      begin
         if (go_sleep)
            sleep_q <= 1'b1;
         if (err_i)
            err_hold <= 1'b1;
         if (start_wait)
            wait_branch <= 1'b1;
         else if (branch_occur_i)
            wait_branch <= 1'b0;
      end
   end

   // one-cycle marker that a branch word sits in decode
   always_ff @(posedge clk)
   begin
      if (rst | sleep_q)
         jump_q <= 1'b0;
      else
         jump_q <= !jump_q & taken & pre_i.will_branch;
   end

   always_ff @(posedge clk)
   begin
      padv_r      <= padv_i;
      took_branch <= branch_occur_i | except_branch_i;
   end

   // exception branch kills the request in the same cycle
   assign req_o            = fetch_req & !except_branch_i;
   assign sleep_o          = sleep_q;
   assign jump_in_decode_o = jump_q;

endmodule

// File: src/fetch_unit.sv
// fetch stage of a small in-order core
// keeps the pc, drives the instruction bus and registers the word for decode
// predecode and bus control both look at each returned word, this module
// merges their results into the next pc and the decode outputs
module fetch_unit
(
   input  logic                         clk,
   input  logic                         rst,
   output fetch_pkg::ibus_req_t         bus_o,
   input  fetch_pkg::ibus_rsp_t         bus_i,
   input  logic                         padv_i,
   input  logic                         branch_occur_i,
   input  logic [fetch_pkg::ADDR_W-1:0] branch_dest_i,
   input  logic                         except_branch_i,
   input  logic                         flag_i,
   input  logic                         flag_set_i,
   input  logic                         flag_clear_i,
   output logic [fetch_pkg::INSN_W-1:0] decode_insn_o,
   output logic [fetch_pkg::ADDR_W-1:0] fetched_pc_o,
   output logic                         fetch_ready_o,
   output logic                         ibus_err_o,
   output logic                         sleep_o
);

   logic [fetch_pkg::ADDR_W-1:0] pc_q;
   logic [fetch_pkg::ADDR_W-1:0] pc_next;
   fetch_pkg::predecode_t        pre;
   logic                         req;
   logic                         jump_in_decode;
   logic                         taken;
   logic                         took_early;

   fetch_predecode u_predecode (
      .insn_i       (bus_i.dat),
      .pc_i         (pc_q),
      .flag_i       (flag_i),
      .flag_set_i   (flag_set_i),
      .flag_clear_i (flag_clear_i),
      .pre_o        (pre)
   );

   fetch_bus_ctrl u_bus_ctrl (
      .clk              (clk),
      .rst              (rst),
      .ack_i            (bus_i.ack),
      .err_i            (bus_i.err),
      .padv_i           (padv_i),
      .except_branch_i  (except_branch_i),
      .branch_occur_i   (branch_occur_i),
      .pre_i            (pre),
      .req_o            (req),
      .sleep_o          (sleep_o),
      .jump_in_decode_o (jump_in_decode)
   );

   assign taken   = bus_i.ack & padv_i;
   // early target only counts on an ack cycle
   assign pc_next = (bus_i.ack & pre.has_target) ? pre.target
                                                 : pc_q + fetch_pkg::ADDR_W'(4);

   assign bus_o.req     = req;
   assign bus_o.adr     = pc_q;
   assign fetch_ready_o = bus_i.ack | jump_in_decode;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc_q         <= fetch_pkg::RESET_PC;
         fetched_pc_o <= fetch_pkg::RESET_PC;
      end
      else if (except_branch_i)
         pc_q <= branch_dest_i;
      else if (taken)
      begin
         pc_q         <= pc_next;
         fetched_pc_o <= pc_q;
      end
      // execute resolved a branch fetch did not already follow
      else if (branch_occur_i & !took_early)
         pc_q <= branch_dest_i;
   end

   // remembers an early redirect so execute's report of it is ignored
   always_ff @(posedge clk)
   begin
      if (rst | sleep_o)
         took_early <= 1'b0;
      else
         took_early <= taken & pre.has_target;
   end

   always_ff @(posedge clk)
   begin
      if (rst | except_branch_i | sleep_o)
         decode_insn_o <= fetch_pkg::NOP_INSN;
      else if (taken)
         decode_insn_o <= bus_i.dat;
      // slot killed on a resolved branch or a failed fetch
      else if (branch_occur_i | bus_i.err)
         decode_insn_o <= fetch_pkg::NOP_INSN;
   end

   always_ff @(posedge clk)
   begin
      if (rst | except_branch_i)
         ibus_err_o <= 1'b0;
      else if (bus_i.err)
         ibus_err_o <= 1'b1;
   end

endmodule

// File: src/insn_rom.sv
// instruction rom on the fetch bus, 64 words starting at the reset pc
// filled through the load port, answers a request one cycle later
// with ack and the word, or err when the address is outside the window
module insn_rom
(
   input  logic                         clk,
   input  logic                         rst,
   input  fetch_pkg::ibus_req_t         bus_i,
   output fetch_pkg::ibus_rsp_t         bus_o,
   input  logic                         load_we_i,
   input  logic [fetch_pkg::ROM_AW-1:0] load_idx_i,
   input  logic [fetch_pkg::INSN_W-1:0] load_dat_i
);

   logic [fetch_pkg::INSN_W-1:0] mem [2**fetch_pkg::ROM_AW];
   logic [fetch_pkg::ADDR_W-1:0] offset;
   logic                         in_range;
   logic                         ack_q;
   logic                         err_q;
   logic [fetch_pkg::INSN_W-1:0] dat_q;

   // byte offset into the window, low two bits ignored
   assign offset   = bus_i.adr - fetch_pkg::RESET_PC;
   assign in_range = (offset[fetch_pkg::ADDR_W-1:fetch_pkg::ROM_AW+2] == '0);

   always_ff @(posedge clk)
   begin
      if (load_we_i)
         mem[load_idx_i] <= load_dat_i;
   end

   // new transfer only starts when no response is on the bus
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         ack_q <= bus_i.req & !ack_q & !err_q & in_range;
         err_q <= bus_i.req & !ack_q & !err_q & !in_range;
      end
      dat_q <= mem[offset[fetch_pkg::ROM_AW+1:2]];
   end

   assign bus_o.ack = ack_q;
   assign bus_o.err = err_q;
   assign bus_o.dat = dat_q;

endmodule

// File: src/fetch_top.sv
// top level of the fetch subsystem
// fetch unit and instruction rom joined by the request and response structs
// the load port fills the rom while the core is held in reset
module fetch_top
(
   input  logic                         clk,
   input  logic                         rst,
   // rom load port
   input  logic                         load_we_i,
   input  logic [fetch_pkg::ROM_AW-1:0] load_idx_i,
   input  logic [fetch_pkg::INSN_W-1:0] load_dat_i,
   // pipeline control
   input  logic                         padv_i,
   input  logic                         branch_occur_i,
   input  logic [fetch_pkg::ADDR_W-1:0] branch_dest_i,
   input  logic                         except_branch_i,
   input  logic                         flag_i,
   input  logic                         flag_set_i,
   input  logic                         flag_clear_i,
   // towards decode
   output logic [fetch_pkg::INSN_W-1:0] decode_insn_o,
   output logic [fetch_pkg::ADDR_W-1:0] fetched_pc_o,
   output logic                         fetch_ready_o,
   output logic                         ibus_err_o,
   output logic                         sleep_o
);

   fetch_pkg::ibus_req_t ibus_req;
   fetch_pkg::ibus_rsp_t ibus_rsp;

   fetch_unit u_fetch (
      .clk             (clk),
      .rst             (rst),
      .bus_o           (ibus_req),
      .bus_i           (ibus_rsp),
      .padv_i          (padv_i),
      .branch_occur_i  (branch_occur_i),
      .branch_dest_i   (branch_dest_i),
      .except_branch_i (except_branch_i),
      .flag_i          (flag_i),
      .flag_set_i      (flag_set_i),
      .flag_clear_i    (flag_clear_i),
      .decode_insn_o   (decode_insn_o),
      .fetched_pc_o    (fetched_pc_o),
      .fetch_ready_o   (fetch_ready_o),
      .ibus_err_o      (ibus_err_o),
      .sleep_o         (sleep_o)
   );

   insn_rom u_rom (
      .clk        (clk),
      .rst        (rst),
      .bus_i      (ibus_req),
      .bus_o      (ibus_rsp),
      .load_we_i  (load_we_i),
      .load_idx_i (load_idx_i),
      .load_dat_i (load_dat_i)
   );

endmodule

// File: tests/fetch_asserts.sv
// bus and sleep protocol checks for the fetch unit
// bound into every fetch_unit instance by the bind below the module
module fetch_asserts
(
   input  logic                 clk,
   input  logic                 rst,
   input  fetch_pkg::ibus_req_t bus_o,
   input  fetch_pkg::ibus_rsp_t bus_i,
   input  logic                 sleep_o
);

   // a waiting request keeps its address until the rom answers
   addr_stable: assert property (@(posedge clk) disable iff (rst)
      bus_o.req && !bus_i.ack && !bus_i.err |=> $stable(bus_o.adr))
      else $error("instruction address changed while a request was waiting");

   // a request seen by the rom gets exactly one of ack or err next cycle
   rsp_one_of: assert property (@(posedge clk) disable iff (rst)
      bus_o.req && !bus_i.ack && !bus_i.err |=> bus_i.ack != bus_i.err)
      else $error("request not answered by exactly one of ack or err");

   // a sleeping core does not touch the bus
   sleep_no_req: assert property (@(posedge clk) disable iff (rst)
      sleep_o |-> !bus_o.req)
      else $error("request high while the fetch unit sleeps");

endmodule

bind fetch_unit fetch_asserts u_asserts (
   .clk     (clk),
   .rst     (rst),
   .bus_o   (bus_o),
   .bus_i   (bus_i),
   .sleep_o (sleep_o)
);

// File: tests/fetch_tb.sv
// testbench for the fetch subsystem
// loads a program per test, lets fetch run until sleep and compares every
// word reaching decode against a walk of the same program
// covers straight code, early branches, back-pressure, jr, sleep and bus errors
module fetch_tb;

   localparam int NUM_TESTS       = 6;
   // sum of the predicted word counts over all tests
   localparam int EXP_WORDS       = 49;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * (64 + 4 + 20) + EXP_WORDS * 8 + 300;
   localparam int WAIT_LIMIT      = 400;

   logic        clk;
   logic        rst;
   logic        load_we;
   logic [5:0]  load_idx;
   logic [31:0] load_dat;
   logic        padv_i = 1'b1;
   logic        branch_occur_i = 1'b0;
   logic [31:0] branch_dest_i = '0;
   logic        except_branch_i;
   logic        flag_i;
   logic        flag_set_i;
   logic        flag_clear_i;
   logic [31:0] decode_insn_o;
   logic [31:0] fetched_pc_o;
   logic        fetch_ready_o;
   logic        ibus_err_o;
   logic        sleep_o;

   // program image and predicted (pc, word) pairs
   logic [31:0] prog [64];
   logic [31:0] exp_pc [$];
   logic [31:0] exp_insn [$];
   int          got_n;
   logic        recording;
   logic [31:0] last_pc;
   // fetch_ready_o one cycle back
   logic        ready_q;
   string       test_name;
   int          mismatches;
   int          failures;
   logic        padv_rand;
   logic [31:0] jr_dest;
   logic [31:0] exc_dest;
   logic [7:0]  fill_lfsr;
   logic [7:0]  padv_lfsr = 8'd63;

   fetch_top UUT (
      .clk             (clk),
      .rst             (rst),
      .load_we_i       (load_we),
      .load_idx_i      (load_idx),
      .load_dat_i      (load_dat),
      .padv_i          (padv_i),
      .branch_occur_i  (branch_occur_i),
      .branch_dest_i   (branch_dest_i),
      .except_branch_i (except_branch_i),
      .flag_i          (flag_i),
      .flag_set_i      (flag_set_i),
      .flag_clear_i    (flag_clear_i),
      .decode_insn_o   (decode_insn_o),
      .fetched_pc_o    (fetched_pc_o),
      .fetch_ready_o   (fetch_ready_o),
      .ibus_err_o      (ibus_err_o),
      .sleep_o         (sleep_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // 8-bit fibonacci lfsr, taps 8 6 5 4
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   // opcode plus signed word offset
   function automatic logic [31:0] encode(input logic [5:0] opc, input int off);
      logic [31:0] o;
      o = off;
      return {opc, o[25:0]};
   endfunction

   function automatic logic in_rom(input logic [31:0] pc);
      logic [31:0] off;
      off = pc - fetch_pkg::RESET_PC;
      return (off < 32'd256) && (pc[1:0] == 2'b00);
   endfunction

   // filler words, msb forced so the opcode is never a control opcode
   task automatic fill_program();
      logic [30:0] bits;
      for (int i = 0; i < 64; i++)
      begin
         bits = '0;
         for (int b = 0; b < 31; b++)
         begin
            fill_lfsr = lfsr_next(fill_lfsr);
            bits = {bits[29:0], fill_lfsr[0]};
         end
         prog[i] = {1'b1, bits};
      end
   endtask

   // reference walk, appends what decode should see starting at start
   function automatic void predict(input logic [31:0] start, input logic flag,
                                   input logic [31:0] jr_to);
      logic [31:0] pc;
      logic [31:0] off;
      logic [31:0] insn;
      logic [31:0] target;
      logic [5:0]  opc;
      logic        jump;
      int          woff;
      pc = start;
      for (int steps = 0; steps < 100; steps++)
      begin
         // fetch beyond the rom ends in a bus error
         if (!in_rom(pc))
            break;
         off  = pc - fetch_pkg::RESET_PC;
         insn = prog[off[7:2]];
         exp_pc.push_back(pc);
         exp_insn.push_back(insn);
         opc    = insn[31:26];
         // signed word count, four bytes per word
         woff   = 32'($signed(insn[25:0]));
         target = pc + 32'(woff * 4);
         jump   = (opc == fetch_pkg::OPC_J) || (opc == fetch_pkg::OPC_JAL) ||
                  (opc == fetch_pkg::OPC_BF && flag) || (opc == fetch_pkg::OPC_BNF && !flag);
         // jump to self is sleep
         if (jump && target == pc)
            break;
         if (opc == fetch_pkg::OPC_JR)
            pc = jr_to;
         else if (jump)
            pc = target;
         else
            pc = pc + 32'd4;
      end
   endfunction

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         mismatches++;
         $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // a new word in decode shows up as a new fetched pc with a real insn
   always @(negedge clk)
   begin
      if (recording && decode_insn_o != fetch_pkg::NOP_INSN && fetched_pc_o != last_pc)
      begin
         last_pc = fetched_pc_o;
         // the word was acked in the cycle before it reached decode
         check("ready", 32'd1, 32'(ready_q));
         if (got_n < exp_pc.size())
         begin
            check("pc", exp_pc[got_n], fetched_pc_o);
            check("insn", exp_insn[got_n], decode_insn_o);
         end
         else
         begin
            failures++;
            $display("%s: extra word %h at %h reached decode", test_name,
                     decode_insn_o, fetched_pc_o);
         end
         got_n++;
      end
      ready_q = fetch_ready_o;
   end

   // pipeline advance, random drops only in the back-pressure test
   always @(posedge clk)
   begin
      if (padv_rand)
      begin
         padv_lfsr <= lfsr_next(padv_lfsr);
         padv_i    <= padv_lfsr[0];
      end
      else
         padv_i <= 1'b1;
   end

   // execute stand-in, resolves a jr one cycle after it reaches decode
   always @(posedge clk)
   begin
      if (rst)
         branch_occur_i <= 1'b0;
      else if (decode_insn_o[31:26] == fetch_pkg::OPC_JR && !branch_occur_i)
         branch_occur_i <= 1'b1;
      else
         branch_occur_i <= 1'b0;
      if (decode_insn_o[31:26] == fetch_pkg::OPC_JR)
         branch_dest_i <= jr_dest;
      else
         branch_dest_i <= exc_dest;
   end

   task automatic wait_flag(input logic for_err, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (n < WAIT_LIMIT && !(for_err ? ibus_err_o : sleep_o))
      begin
         @(negedge clk);
         n++;
      end
      if (n == WAIT_LIMIT)
      begin
         failures++;
         $display("%s: %s never came", test_name, what);
      end
   endtask

   // exc_kind 0 none, 1 wake from sleep, 2 recover from bus error
   task automatic run_test(input string name, input logic flag_val, input logic rand_padv,
                           input logic [1:0] exc_kind, input logic [31:0] exc_to);
      test_name = name;
      exp_pc.delete();
      exp_insn.delete();
      predict(fetch_pkg::RESET_PC, flag_val, jr_dest);
      if (exc_kind != 2'd0)
         predict(exc_to, flag_val, jr_dest);
      exc_dest = exc_to;
      @(posedge clk);
      rst       <= 1'b1;
      flag_i    <= flag_val;
      padv_rand <= rand_padv;
      // program goes in while the core is held in reset
      for (int i = 0; i < 64; i++)
      begin
         load_we  <= 1'b1;
         load_idx <= 6'(i);
         load_dat <= prog[i];
         @(posedge clk);
      end
      load_we   <= 1'b0;
      got_n     = 0;
      last_pc   = '1;
      recording = 1'b1;
      repeat (3) @(posedge clk);
      // outputs sit at their reset values before fetch starts
      @(negedge clk);
      check("ready after reset", 32'd0, 32'(fetch_ready_o));
      check("sleep after reset", 32'd0, 32'(sleep_o));
      check("err after reset", 32'd0, 32'(ibus_err_o));
      check("decode after reset", fetch_pkg::NOP_INSN, decode_insn_o);
      @(posedge clk);
      rst <= 1'b0;
      wait_flag(exc_kind == 2'd2, (exc_kind == 2'd2) ? "bus error" : "sleep");
      if (exc_kind != 2'd0)
      begin
         repeat (6) @(posedge clk);
         except_branch_i <= 1'b1;
         @(posedge clk);
         except_branch_i <= 1'b0;
         wait_flag(1'b0, "sleep after exception");
         check("err flag", 32'd0, 32'(ibus_err_o));
      end
      // quiet period, nothing more may reach decode
      repeat (10) @(posedge clk);
      recording = 1'b0;
      if (got_n != exp_pc.size())
      begin
         failures++;
         $display("%s: %0d words reached decode, %0d expected", test_name, got_n,
                  exp_pc.size());
      end
   endtask

   initial
   begin
      rst             = 1'b1;
      load_we         = 1'b0;
      load_idx        = '0;
      load_dat        = '0;
      except_branch_i = 1'b0;
      flag_i          = 1'b0;
      flag_set_i      = 1'b0;
      flag_clear_i    = 1'b0;
      padv_rand       = 1'b0;
      recording       = 1'b0;
      ready_q         = 1'b0;
      got_n           = 0;
      last_pc         = '1;
      mismatches      = 0;
      failures        = 0;
      fill_lfsr       = 8'd63;
      jr_dest         = fetch_pkg::RESET_PC + 32'd120;
      exc_dest        = fetch_pkg::RESET_PC;

      // straight code ending in sleep, then the same with stalls
      fill_program();
      prog[10] = encode(fetch_pkg::OPC_J, 0);
      run_test("straight", 1'b0, 1'b0, 2'd0, 32'd0);
      run_test("backpressure", 1'b0, 1'b1, 2'd0, 32'd0);

      // early branches with the flag set, bnf falls through
      fill_program();
      prog[1]  = encode(fetch_pkg::OPC_J, 4);
      prog[5]  = encode(fetch_pkg::OPC_JAL, 3);
      prog[8]  = encode(fetch_pkg::OPC_BF, 4);
      prog[12] = encode(fetch_pkg::OPC_BNF, 5);
      prog[14] = encode(fetch_pkg::OPC_J, 6);
      prog[21] = encode(fetch_pkg::OPC_J, -4);
      prog[17] = encode(fetch_pkg::OPC_J, 0);
      run_test("branches", 1'b1, 1'b0, 2'd0, 32'd0);

      // register jump, resolved by execute to word 30
      fill_program();
      prog[2]  = encode(fetch_pkg::OPC_JR, 0);
      prog[32] = encode(fetch_pkg::OPC_J, 0);
      run_test("jr", 1'b0, 1'b0, 2'd0, 32'd0);

      // sleep early, woken by exception to word 40
      fill_program();
      prog[1]  = encode(fetch_pkg::OPC_J, 0);
      prog[43] = encode(fetch_pkg::OPC_J, 0);
      run_test("sleep", 1'b0, 1'b0, 2'd1, fetch_pkg::RESET_PC + 32'd160);

      // jump far outside the rom, recover at word 50
      fill_program();
      prog[1]  = encode(fetch_pkg::OPC_J, 1000);
      prog[52] = encode(fetch_pkg::OPC_J, 0);
      run_test("bus_err", 1'b0, 1'b0, 2'd2, fetch_pkg::RESET_PC + 32'd200);

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches + failures == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // limit sized from load time plus eight cycles per expected word
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired in test %s, fetch stopped making progress", test_name);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: fetch_top.f
src/fetch_pkg.sv
src/fetch_predecode.sv
src/fetch_bus_ctrl.sv
src/fetch_unit.sv
src/insn_rom.sv
src/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator build and run for the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= fetch_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
